// ==== common/gb_consts.svh ====
// ------------------------------
// game console system bus constants
// widths, register addresses, region bounds,
// vector rule and reset values
// ------------------------------
`ifndef GB_CONSTS_SVH
`define GB_CONSTS_SVH

// bus and memory widths
`define GB_ADDR_W        16
`define GB_DATA_W        8
`define GB_IRQ_N         5    // vblank, lcd, timer, serial, joypad
`define GB_WRAM_AW       15   // 32 KiB, eight 4 KiB banks
`define GB_HRAM_AW       7

// io register addresses
`define GB_A_P1          16'hFF00
`define GB_A_IF          16'hFF0F
`define GB_A_KEY1        16'hFF4D
`define GB_A_BOOT        16'hFF50
`define GB_A_SVBK        16'hFF70
`define GB_A_SPARE72     16'hFF72
`define GB_A_SPARE73     16'hFF73
`define GB_A_SPARE74     16'hFF74
`define GB_A_SPARE75     16'hFF75
`define GB_A_IE          16'hFFFF

// region bounds
`define GB_WRAM_LO       16'hC000
`define GB_WRAM_HI       16'hFDFF   // top of echo area
`define GB_HRAM_LO       16'hFF80
`define GB_HRAM_HI       16'hFFFE

// vector rule, fixed read values, reset values
`define GB_IRQ_VEC_BASE  8'h40
`define GB_IRQ_VEC_STEP  8'd8
`define GB_FAST_BOOT_FLAG 8'h42
`define GB_OPEN_BUS      8'hFF
`define GB_BOOT_OFF_CGB  8'h11      // cgb boot rom unmap value
`define GB_SVBK_RST      3'd1
`define GB_AXIL_OKAY     2'b00

`endif

// ==== common/gb_bus_pkg.sv ====
// ------------------------------
// game console system bus types
// internal bus, region codes, event lines
// and axi4-lite channel bundles
// ------------------------------
`include "gb_consts.svh"

package gb_bus_pkg;

	// one internal byte access
	typedef struct packed {
		logic [`GB_ADDR_W-1:0] addr;
		logic [`GB_DATA_W-1:0] wdata;
		logic                  we;     // low for a read
	} bus_req_t;

	// access target, from addr_decode
	typedef enum logic [4:0] {
		REG_NONE,
		WRAM,
		HRAM,
		REG_IE,
		REG_IF,
		REG_P1,          // joypad
		REG_BOOT,
		REG_KEY1,
		REG_SVBK,
		REG_SPARE72,
		REG_SPARE73,
		REG_SPARE74,
		REG_SPARE75
	} region_e;

	// event lines, vblank in bit 0
	typedef struct packed {
		logic serial;
		logic timer;
		logic lcd;
		logic vblank;
	} irq_src_t;

	// master to slave
	typedef struct packed {
		logic [`GB_ADDR_W-1:0] awaddr;
		logic                  awvalid;
		logic [`GB_DATA_W-1:0] wdata;
		logic                  wstrb;
		logic                  wvalid;
		logic                  bready;
		logic [`GB_ADDR_W-1:0] araddr;
		logic                  arvalid;
		logic                  rready;
	} axil_req_t;

	// slave to master
	typedef struct packed {
		logic                  awready;
		logic                  wready;
		logic [1:0]            bresp;
		logic                  bvalid;
		logic                  arready;
		logic [`GB_DATA_W-1:0] rdata;
		logic [1:0]            rresp;
		logic                  rvalid;
	} axil_rsp_t;

endpackage

// ==== logic/axil_cpu_port.sv ====
`timescale 1ns/1ps
// ------------------------------
// axi4-lite cpu port
// one transaction at a time, turned into a
// single-cycle byte access on the internal bus
// ------------------------------
`include "gb_consts.svh"

module axil_cpu_port (
	input  logic                  clk_sys,
	input  logic                  reset_ss,
	input  gb_bus_pkg::axil_req_t axil_req_i,
	output gb_bus_pkg::axil_rsp_t axil_rsp_o,
	output gb_bus_pkg::bus_req_t  bus_req_o,
	output logic                  bus_valid_o,
	input  logic [`GB_DATA_W-1:0] rdata_i
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_RWAIT,   // ram and region register settle
		ST_RRESP,
		ST_WRESP
	} state_e;

	state_e                state_q;
	logic [`GB_ADDR_W-1:0] addr_q;    // held for the read wait cycle
	logic [`GB_DATA_W-1:0] rdata_q;
	logic                  wr_acc;
	logic                  rd_acc;

	// accept only when nothing is pending, write wins
	assign wr_acc = (state_q == ST_IDLE) && axil_req_i.awvalid && axil_req_i.wvalid;
	assign rd_acc = (state_q == ST_IDLE) && axil_req_i.arvalid && !wr_acc;

	assign bus_valid_o = wr_acc | rd_acc;   // one-cycle strobe

	always_comb begin
		bus_req_o.addr  = addr_q;               // keeps last address between accesses
		bus_req_o.wdata = axil_req_i.wdata;
		bus_req_o.we    = 1'b0;
		if (wr_acc) begin
			bus_req_o.addr = axil_req_i.awaddr;
			bus_req_o.we   = axil_req_i.wstrb;  // no strobe, no store
		end else if (rd_acc) begin
			bus_req_o.addr = axil_req_i.araddr;
		end
	end

	// ------------------------------
	// fsm
	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			state_q <= ST_IDLE;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (wr_acc)
						state_q <= ST_WRESP;
					else if (rd_acc)
						state_q <= ST_RWAIT;
				end
				ST_RWAIT: state_q <= ST_RRESP;  // data captured here
				ST_RRESP: if (axil_req_i.rready) state_q <= ST_IDLE;
				ST_WRESP: if (axil_req_i.bready) state_q <= ST_IDLE;
				default:  state_q <= ST_IDLE;
			endcase
		end
	end

	// address and read data
	always_ff @(posedge clk_sys) begin
		if (bus_valid_o)
			addr_q <= bus_req_o.addr;
		if (state_q == ST_RWAIT)
			rdata_q <= rdata_i;   // held until rready
	end

	always_comb begin
		axil_rsp_o.awready = wr_acc;
		axil_rsp_o.wready  = wr_acc;
		axil_rsp_o.bresp   = `GB_AXIL_OKAY;
		axil_rsp_o.bvalid  = (state_q == ST_WRESP);
		axil_rsp_o.arready = rd_acc;
		axil_rsp_o.rdata   = rdata_q;
		axil_rsp_o.rresp   = `GB_AXIL_OKAY;
		axil_rsp_o.rvalid  = (state_q == ST_RRESP);
	end

endmodule

// ==== logic/addr_decode.sv ====
`timescale 1ns/1ps
// ------------------------------
// memory map decoder
// bus address and mode inputs to one region code
// ------------------------------
`include "gb_consts.svh"

module addr_decode (
	input  gb_bus_pkg::bus_req_t bus_req_i,
	input  logic                 cgb_mode_i,
	input  logic                 cgb_game_i,
	input  logic                 boot_rom_on_i,
	output gb_bus_pkg::region_e  region_o
);

	import gb_bus_pkg::*;

	logic [`GB_ADDR_W-1:0] addr;
	logic                  cgb_game;  // cgb hardware running a cgb game
	logic                  svbk_en;   // also open while the boot rom runs

	assign addr     = bus_req_i.addr;
	assign cgb_game = cgb_mode_i & cgb_game_i;
	assign svbk_en  = cgb_mode_i & (cgb_game_i | boot_rom_on_i);

	always_comb begin
		region_o = REG_NONE;
		if (addr >= `GB_WRAM_LO && addr <= `GB_WRAM_HI) begin
			region_o = WRAM;      // e000-fdff mirrors c000
		end else if (addr >= `GB_HRAM_LO && addr <= `GB_HRAM_HI) begin
			region_o = HRAM;
		end else begin
			case (addr)
				`GB_A_IE:      region_o = REG_IE;
				`GB_A_IF:      region_o = REG_IF;
				`GB_A_P1:      region_o = REG_P1;
				`GB_A_BOOT:    region_o = REG_BOOT;
				`GB_A_KEY1:    if (cgb_game) region_o = REG_KEY1;
				`GB_A_SVBK:    if (svbk_en) region_o = REG_SVBK;
				`GB_A_SPARE72: if (cgb_mode_i) region_o = REG_SPARE72;
				`GB_A_SPARE73: if (cgb_mode_i) region_o = REG_SPARE73;
				`GB_A_SPARE74: if (cgb_game) region_o = REG_SPARE74;
				`GB_A_SPARE75: if (cgb_mode_i) region_o = REG_SPARE75;
				default:       region_o = REG_NONE;   // dropped or unmapped
			endcase
		end
	end

endmodule

// ==== interrupts/irq_ctrl.sv ====
`timescale 1ns/1ps
// ------------------------------
// interrupt controller
// ie/if registers, event edge capture,
// priority vector and acknowledge clearing
// ------------------------------
`include "gb_consts.svh"

module irq_ctrl (
	input  logic                  clk_sys,
	input  logic                  reset_ss,
	input  gb_bus_pkg::bus_req_t  bus_req_i,
	input  logic                  bus_valid_i,
	input  gb_bus_pkg::region_e   region_i,
	input  gb_bus_pkg::irq_src_t  irq_src_i,
	input  logic [3:0]            joy_din_i,
	input  logic                  irq_ack_i,
	output logic [`GB_DATA_W-1:0] rdata_o,
	output logic                  irq_o,
	output logic [7:0]            irq_vector_o
);

	import gb_bus_pkg::*;

	logic [`GB_DATA_W-1:0] ie_q;
	logic [`GB_IRQ_N-1:0]  if_q;
	irq_src_t              src_q;     // event levels, last cycle
	logic                  ack_q;
	logic [3:0]            joy_s1;    // synchroniser
	logic [3:0]            joy_s2;
	logic [3:0]            joy_s3;    // edge detect
	logic                  joy_fall;
	logic [`GB_IRQ_N-1:0]  set_ev;
	logic [`GB_IRQ_N-1:0]  pend;
	logic [`GB_IRQ_N-1:0]  lowest;
	logic [`GB_IRQ_N-1:0]  clr_ack;
	logic                  wr;

	assign wr       = bus_valid_i & bus_req_i.we;
	assign joy_fall = |(joy_s3 & ~joy_s2);           // any key line going low
	assign set_ev   = {joy_fall, irq_src_i & ~src_q};
	assign pend     = ie_q[`GB_IRQ_N-1:0] & if_q;
	assign lowest   = pend & (~pend + 1'b1);         // one-hot, highest priority
	assign clr_ack  = (ack_q & ~irq_ack_i) ? lowest : '0;
	assign irq_o    = |pend;

	// vector of the lowest pending bit
	always_comb begin
		irq_vector_o = 8'h00;
		for (int i = `GB_IRQ_N - 1; i >= 0; i--) begin
			if (pend[i])
				irq_vector_o = `GB_IRQ_VEC_BASE + 8'(i) * `GB_IRQ_VEC_STEP;
		end
	end

	always_comb begin
		case (region_i)
			REG_IE:  rdata_o = ie_q;
			REG_IF:  rdata_o = {{(`GB_DATA_W - `GB_IRQ_N){1'b1}}, if_q}; // unused bits as 1
			default: rdata_o = `GB_OPEN_BUS;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			ie_q   <= '0;
			if_q   <= '0;
			src_q  <= '0;
			ack_q  <= 1'b0;
			joy_s1 <= '0;
			joy_s2 <= '0;
			joy_s3 <= '0;
		end else begin
			src_q  <= irq_src_i;
			ack_q  <= irq_ack_i;
			joy_s1 <= joy_din_i;
			joy_s2 <= joy_s1;
			joy_s3 <= joy_s2;
			if_q   <= (if_q | set_ev) & ~clr_ack;
			if (wr && region_i == REG_IE)
				ie_q <= bus_req_i.wdata;
			if (wr && region_i == REG_IF)
				if_q <= bus_req_i.wdata[`GB_IRQ_N-1:0];  // overrides same-cycle events
		end
	end

endmodule

// ==== memory/internal_ram.sv ====
`timescale 1ns/1ps
// ------------------------------
// internal ram
// banked work ram with echo, svbk, high ram
// ------------------------------
`include "gb_consts.svh"

module internal_ram (
	input  logic                  clk_sys,
	input  logic                  reset_ss,
	input  gb_bus_pkg::bus_req_t  bus_req_i,
	input  logic                  bus_valid_i,
	input  gb_bus_pkg::region_e   region_i,
	output logic [`GB_DATA_W-1:0] rdata_o
);

	import gb_bus_pkg::*;

	logic [`GB_DATA_W-1:0]  wram [0:(1 << `GB_WRAM_AW)-1];
	logic [`GB_DATA_W-1:0]  hram [0:(1 << `GB_HRAM_AW)-2];   // ff80-fffe
	logic [2:0]             svbk_q;
	logic [2:0]             bank;
	logic [`GB_WRAM_AW-1:0] wram_a;
	logic [`GB_HRAM_AW-1:0] hram_a;
	logic                   wr;

	assign wr     = bus_valid_i & bus_req_i.we;
	assign bank   = bus_req_i.addr[12] ? svbk_q : 3'd0;    // lower 4k always bank 0
	assign wram_a = {bank, bus_req_i.addr[11:0]};
	assign hram_a = bus_req_i.addr[`GB_HRAM_AW-1:0];

	// bank select, 0 maps to 1
	always_ff @(posedge clk_sys) begin
		if (reset_ss)
			svbk_q <= `GB_SVBK_RST;
		else if (wr && region_i == REG_SVBK)
			svbk_q <= (bus_req_i.wdata[2:0] == 3'd0) ? 3'd1 : bus_req_i.wdata[2:0];
	end

	// ram arrays and registered read data
	always_ff @(posedge clk_sys) begin
		if (bus_valid_i) begin
			case (region_i)
				WRAM: begin
					if (bus_req_i.we)
						wram[wram_a] <= bus_req_i.wdata;
					rdata_o <= wram[wram_a];
				end
				HRAM: begin
					if (bus_req_i.we)
						hram[hram_a] <= bus_req_i.wdata;
					rdata_o <= hram[hram_a];
				end
				REG_SVBK: rdata_o <= {5'h1F, svbk_q};
				default:  rdata_o <= `GB_OPEN_BUS;
			endcase
		end
	end

endmodule

// ==== logic/io_regs.sv ====
`timescale 1ns/1ps
// ------------------------------
// misc io registers
// joypad select, boot rom disable, key1 speed
// switch, spare cgb registers ff72-ff75
// ------------------------------
`include "gb_consts.svh"

module io_regs (
	input  logic                  clk_sys,
	input  logic                  reset_ss,
	input  gb_bus_pkg::bus_req_t  bus_req_i,
	input  logic                  bus_valid_i,
	input  gb_bus_pkg::region_e   region_i,
	input  logic                  cgb_mode_i,
	input  logic                  fast_boot_i,
	input  logic [3:0]            joy_din_i,
	input  logic                  stop_i,
	output logic [`GB_DATA_W-1:0] rdata_o,
	output logic [1:0]            joy_sel_o,
	output logic                  speed_o,
	output logic                  boot_rom_on_o
);

	import gb_bus_pkg::*;

	logic [1:0]            joy_sel_q;   // p15/p14
	logic                  boot_on_q;
	logic                  prepare_q;   // key1 bit 0
	logic                  speed_q;     // 1 = double speed
	logic [`GB_DATA_W-1:0] spare72_q;
	logic [`GB_DATA_W-1:0] spare73_q;
	logic [`GB_DATA_W-1:0] spare74_q;
	logic [2:0]            spare75_q;   // bits 6:4 only
	logic [`GB_DATA_W-1:0] wdata;
	logic                  wr;

	assign wr            = bus_valid_i & bus_req_i.we;
	assign wdata         = bus_req_i.wdata;
	assign joy_sel_o     = joy_sel_q;
	assign speed_o       = speed_q;
	assign boot_rom_on_o = boot_on_q;

	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			joy_sel_q <= 2'b00;
			boot_on_q <= 1'b1;
			prepare_q <= 1'b0;
			speed_q   <= 1'b0;
			spare72_q <= '0;
			spare73_q <= '0;
			spare74_q <= '0;
			spare75_q <= '0;
		end else begin
			if (wr) begin
				case (region_i)
					REG_P1:      joy_sel_q <= wdata[5:4];
					REG_BOOT: begin
						// cgb needs 11h, dmg any value with bit 0
						if (cgb_mode_i ? (wdata == `GB_BOOT_OFF_CGB) : wdata[0])
							boot_on_q <= 1'b0;
					end
					REG_KEY1:    prepare_q <= wdata[0];
					REG_SPARE72: spare72_q <= wdata;
					REG_SPARE73: spare73_q <= wdata;
					REG_SPARE74: spare74_q <= wdata;
					REG_SPARE75: spare75_q <= wdata[6:4];
					default:     ;
				endcase
			end
			// stop with prepare armed flips speed
			if (stop_i && prepare_q && cgb_mode_i) begin
				speed_q   <= ~speed_q;
				prepare_q <= 1'b0;
			end
		end
	end

	always_comb begin
		case (region_i)
			REG_P1:      rdata_o = {2'b11, joy_sel_q, joy_din_i};
			REG_BOOT:    rdata_o = (fast_boot_i && boot_on_q) ? `GB_FAST_BOOT_FLAG : `GB_OPEN_BUS;
			REG_KEY1:    rdata_o = {speed_q, 6'h3F, prepare_q};
			REG_SPARE72: rdata_o = spare72_q;
			REG_SPARE73: rdata_o = spare73_q;
			REG_SPARE74: rdata_o = spare74_q;
			REG_SPARE75: rdata_o = {1'b1, spare75_q, 4'hF};
			default:     rdata_o = `GB_OPEN_BUS;
		endcase
	end

endmodule

// ==== logic/gb_sys_bus.sv ====
`timescale 1ns/1ps
// ------------------------------
// game console system bus core
// axi4-lite cpu port, decode, ram, interrupts,
// io registers and the read data mux
// ------------------------------
`include "gb_consts.svh"

module gb_sys_bus (
	input  logic                  clk_sys,
	input  logic                  reset_ss,
	input  gb_bus_pkg::axil_req_t axil_req_i,
	output gb_bus_pkg::axil_rsp_t axil_rsp_o,
	input  logic                  cgb_mode_i,
	input  logic                  cgb_game_i,
	input  logic                  fast_boot_i,
	input  gb_bus_pkg::irq_src_t  irq_src_i,
	input  logic [3:0]            joy_din_i,
	input  logic                  irq_ack_i,
	input  logic                  stop_i,
	output logic                  irq_o,
	output logic [7:0]            irq_vector_o,
	output logic [1:0]            joy_sel_o,
	output logic                  speed_o,
	output logic                  boot_rom_on_o
);

	import gb_bus_pkg::*;

	bus_req_t              bus_req;
	logic                  bus_valid;
	region_e               region;
	region_e               region_q;    // region of the last strobe
	logic [`GB_DATA_W-1:0] rdata;
	logic [`GB_DATA_W-1:0] ram_rdata;
	logic [`GB_DATA_W-1:0] irq_rdata;
	logic [`GB_DATA_W-1:0] io_rdata;
	logic                  boot_rom_on;

	assign boot_rom_on_o = boot_rom_on;

	axil_cpu_port u_port (
		.clk_sys     (clk_sys),
		.reset_ss    (reset_ss),
		.axil_req_i  (axil_req_i),
		.axil_rsp_o  (axil_rsp_o),
		.bus_req_o   (bus_req),
		.bus_valid_o (bus_valid),
		.rdata_i     (rdata)
	);

	addr_decode u_decode (
		.bus_req_i     (bus_req),
		.cgb_mode_i    (cgb_mode_i),
		.cgb_game_i    (cgb_game_i),
		.boot_rom_on_i (boot_rom_on),
		.region_o      (region)
	);

	irq_ctrl u_irq (
		.clk_sys      (clk_sys),
		.reset_ss     (reset_ss),
		.bus_req_i    (bus_req),
		.bus_valid_i  (bus_valid),
		.region_i     (region),
		.irq_src_i    (irq_src_i),
		.joy_din_i    (joy_din_i),
		.irq_ack_i    (irq_ack_i),
		.rdata_o      (irq_rdata),
		.irq_o        (irq_o),
		.irq_vector_o (irq_vector_o)
	);

	internal_ram u_ram (
		.clk_sys     (clk_sys),
		.reset_ss    (reset_ss),
		.bus_req_i   (bus_req),
		.bus_valid_i (bus_valid),
		.region_i    (region),
		.rdata_o     (ram_rdata)
	);

	io_regs u_io (
		.clk_sys       (clk_sys),
		.reset_ss      (reset_ss),
		.bus_req_i     (bus_req),
		.bus_valid_i   (bus_valid),
		.region_i      (region),
		.cgb_mode_i    (cgb_mode_i),
		.fast_boot_i   (fast_boot_i),
		.joy_din_i     (joy_din_i),
		.stop_i        (stop_i),
		.rdata_o       (io_rdata),
		.joy_sel_o     (joy_sel_o),
		.speed_o       (speed_o),
		.boot_rom_on_o (boot_rom_on)
	);

	// ------------------------------
	// read data select, one cycle behind the strobe
	always_ff @(posedge clk_sys) begin
		if (reset_ss)
			region_q <= REG_NONE;
		else if (bus_valid)
			region_q <= region;
	end

	always_comb begin
		case (region_q)
			WRAM, HRAM, REG_SVBK: rdata = ram_rdata;   // registered in the ram block
			REG_IE, REG_IF:       rdata = irq_rdata;
			REG_NONE:             rdata = `GB_OPEN_BUS;
			default:              rdata = io_rdata;
		endcase
	end

endmodule

// ==== verification/tb_axil_tasks.svh ====
// ------------------------------
// axi4-lite master tasks
// byte writes and reads on the falling edge,
// random bready/rready back-pressure
// ------------------------------
`ifndef TB_AXIL_TASKS_SVH
`define TB_AXIL_TASKS_SVH

// one byte write, waits for accept and response
task automatic axil_write(input logic [15:0] a, input logic [7:0] wd);
	@(negedge clk_sys);
	axil_req.awaddr  = a;
	axil_req.awvalid = 1'b1;
	axil_req.wdata   = wd;
	axil_req.wstrb   = 1'b1;
	axil_req.wvalid  = 1'b1;
	axil_req.bready  = 1'($urandom_range(1));
	do begin
		@(negedge clk_sys);
	end while (!aw_hs_q);
	axil_req.awvalid = 1'b0;
	axil_req.wvalid  = 1'b0;
	while (!b_hs_q) begin
		axil_req.bready = 1'($urandom_range(1));   // random back-pressure
		@(negedge clk_sys);
	end
	axil_req.bready = 1'b0;
	check_byte("bresp", 8'h00, {6'b0, resp_q});    // always okay
endtask

// one byte read, data taken at the r handshake
task automatic axil_read(input logic [15:0] a, output logic [7:0] got);
	@(negedge clk_sys);
	axil_req.araddr  = a;
	axil_req.arvalid = 1'b1;
	axil_req.rready  = 1'($urandom_range(1));
	do begin
		@(negedge clk_sys);
	end while (!ar_hs_q);
	axil_req.arvalid = 1'b0;
	while (!r_hs_q) begin
		axil_req.rready = 1'($urandom_range(1));
		@(negedge clk_sys);
	end
	axil_req.rready = 1'b0;
	got = rdata_q;
	check_byte("rresp", 8'h00, {6'b0, resp_q});
endtask

// write and read raised together, read held through the write response
task automatic write_read_race(input logic [15:0] a, input logic [7:0] wd,
	output logic [7:0] got);
	@(negedge clk_sys);
	axil_req.awaddr  = a;
	axil_req.awvalid = 1'b1;
	axil_req.wdata   = wd;
	axil_req.wstrb   = 1'b1;
	axil_req.wvalid  = 1'b1;
	axil_req.araddr  = a;
	axil_req.arvalid = 1'b1;
	axil_req.bready  = 1'b0;
	axil_req.rready  = 1'b0;
	do begin
		@(negedge clk_sys);
	end while (!aw_hs_q && !ar_hs_q);
	assert (aw_hs_q && !ar_hs_q)
	else fail_run("read address was accepted ahead of a write raised in the same cycle");
	axil_req.awvalid = 1'b0;
	axil_req.wvalid  = 1'b0;
	repeat (3) @(negedge clk_sys);   // bvalid waiting, arvalid still up
	axil_req.bready = 1'b1;
	do begin
		@(negedge clk_sys);
	end while (!b_hs_q);
	axil_req.bready = 1'b0;
	do begin
		@(negedge clk_sys);
	end while (!ar_hs_q);
	axil_req.arvalid = 1'b0;
	axil_req.rready  = 1'b1;
	do begin
		@(negedge clk_sys);
	end while (!r_hs_q);
	axil_req.rready = 1'b0;
	got = rdata_q;
endtask

`endif

// ==== verification/tb_gb_sys_bus.sv ====
`timescale 1ns/1ps
// ------------------------------
// system bus core testbench
// axi4-lite traffic against a reference model
// with protocol properties and a cycle limit
// ------------------------------
`include "gb_consts.svh"

module tb_gb_sys_bus;

	import gb_bus_pkg::*;

	localparam int SEED       = 56;
	localparam int MAX_CYCLES = 4000;   // about twice the stimulus
	localparam int RAM_WRITES = 48;

	logic        clk_sys;
	logic        reset_ss;
	axil_req_t   axil_req;
	axil_rsp_t   axil_rsp;
	logic        cgb_mode;
	logic        cgb_game;
	logic        fast_boot;
	irq_src_t    irq_src;
	logic [3:0]  joy_din;
	logic        irq_ack;
	logic        stop;
	logic        irq;
	logic [7:0]  irq_vector;
	logic [1:0]  joy_sel;
	logic        speed;
	logic        boot_rom_on;

	// handshakes seen at the last rising edge
	logic        aw_hs_q;
	logic        ar_hs_q;
	logic        b_hs_q;
	logic        r_hs_q;
	logic [1:0]  resp_q;
	logic [7:0]  rdata_q;
	int          cycle_cnt;

	// reference model
	logic [7:0]  ram_model [int];
	int          svbk_m;
	logic [7:0]  ie_m;
	logic [4:0]  if_m;
	logic        prep_m;
	logic        spd_m;

	string       test_name;
	logic [15:0] addr;
	logic [7:0]  data;
	logic [7:0]  rd;
	logic [15:0] addrs [$];

	gb_sys_bus DUT (
		.clk_sys       (clk_sys),
		.reset_ss      (reset_ss),
		.axil_req_i    (axil_req),
		.axil_rsp_o    (axil_rsp),
		.cgb_mode_i    (cgb_mode),
		.cgb_game_i    (cgb_game),
		.fast_boot_i   (fast_boot),
		.irq_src_i     (irq_src),
		.joy_din_i     (joy_din),
		.irq_ack_i     (irq_ack),
		.stop_i        (stop),
		.irq_o         (irq),
		.irq_vector_o  (irq_vector),
		.joy_sel_o     (joy_sel),
		.speed_o       (speed),
		.boot_rom_on_o (boot_rom_on)
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;   // 100 MHz
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_byte(input string what, input logic [7:0] exp, input logic [7:0] got);
		assert (got === exp)
		else fail_run($sformatf("CHECK FAILED %s: %s expected %02h actual %02h",
			test_name, what, exp, got));
	endtask

	`include "tb_axil_tasks.svh"

	// ------------------------------
	// handshake monitor and cycle limit
	always @(posedge clk_sys) begin
		aw_hs_q <= axil_req.awvalid & axil_req.wvalid & axil_rsp.awready & axil_rsp.wready;
		ar_hs_q <= axil_req.arvalid & axil_rsp.arready;
		b_hs_q  <= axil_rsp.bvalid & axil_req.bready;
		r_hs_q  <= axil_rsp.rvalid & axil_req.rready;
		if (axil_rsp.bvalid && axil_req.bready)
			resp_q <= axil_rsp.bresp;
		if (axil_rsp.rvalid && axil_req.rready) begin
			resp_q  <= axil_rsp.rresp;
			rdata_q <= axil_rsp.rdata;
		end
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == MAX_CYCLES)
			fail_run($sformatf("timeout: run still busy after %0d cycles", MAX_CYCLES));
	end

	// ------------------------------
	// protocol properties
	assert property (@(posedge clk_sys) disable iff (reset_ss)
		(axil_req.arvalid && axil_rsp.arready) |-> ##1 !axil_rsp.rvalid ##1 axil_rsp.rvalid)
	else fail_run("rvalid did not rise exactly two cycles after the read address handshake");

	assert property (@(posedge clk_sys) disable iff (reset_ss)
		(axil_req.awvalid && axil_rsp.awready && axil_req.wvalid && axil_rsp.wready)
		|=> axil_rsp.bvalid)
	else fail_run("bvalid did not rise one cycle after the write accept");

	assert property (@(posedge clk_sys) disable iff (reset_ss)
		(axil_rsp.rvalid && !axil_req.rready) |=> (axil_rsp.rvalid && $stable(axil_rsp.rdata)))
	else fail_run("read response dropped or changed before rready");

	assert property (@(posedge clk_sys) disable iff (reset_ss)
		(axil_rsp.bvalid && !axil_req.bready) |=> axil_rsp.bvalid)
	else fail_run("write response dropped before bready");

	assert property (@(posedge clk_sys) disable iff (reset_ss)
		(axil_rsp.bvalid || axil_rsp.rvalid)
		|-> !(axil_rsp.awready || axil_rsp.wready || axil_rsp.arready))
	else fail_run("an address was accepted while a response was still waiting");

	assert property (@(posedge clk_sys) reset_ss |=> !(axil_rsp.bvalid || axil_rsp.rvalid))
	else fail_run("a response valid was high after reset");

	assert property (@(posedge clk_sys) disable iff (reset_ss)
		irq == (irq_vector != 8'h00))
	else fail_run("irq_o and irq_vector_o disagree about a pending interrupt");

	// ------------------------------
	// model helpers

	// echo folds onto c000 and the upper 4k follows the bank
	function automatic int ram_key(input logic [15:0] a, input int bank);
		logic [12:0] off;
		off = 13'(a - 16'hC000);
		if (a >= 16'hFF80)
			return 32'h10000 + int'(a);
		if (off[12])
			return bank * 4096 + int'(off[11:0]);
		return int'(off[11:0]);
	endfunction

	// 40h plus 8 per bit for the lowest enabled flag
	function automatic logic [7:0] expected_vector(input logic [7:0] ie, input logic [4:0] fl);
		logic [4:0] pend;
		pend = ie[4:0] & fl;
		for (int i = 0; i < 5; i++) begin
			if (pend[i])
				return 8'h40 + 8'(8 * i);
		end
		return 8'h00;
	endfunction

	task automatic read_check(input logic [15:0] a, input logic [7:0] exp);
		logic [7:0] got;
		axil_read(a, got);
		check_byte($sformatf("read %04h", a), exp, got);
	endtask

	task automatic ram_write(input logic [15:0] a, input logic [7:0] wd);
		axil_write(a, wd);
		ram_model[ram_key(a, svbk_m)] = wd;
	endtask

	task automatic check_irq();
		check_byte("irq_vector_o", expected_vector(ie_m, if_m), irq_vector);
		check_byte("irq_o", {7'b0, |(ie_m[4:0] & if_m)}, {7'b0, irq});
	endtask

	task automatic pulse_src(input irq_src_t lines);
		@(negedge clk_sys);
		irq_src = lines;
		@(negedge clk_sys);
		irq_src = '0;
		repeat (2) @(negedge clk_sys);
		if_m = if_m | {1'b0, lines};
	endtask

	// falling edge of the ack clears the lowest enabled flag
	task automatic pulse_ack();
		logic done;
		done = 1'b0;
		@(negedge clk_sys);
		irq_ack = 1'b1;
		@(negedge clk_sys);
		irq_ack = 1'b0;
		repeat (2) @(negedge clk_sys);
		for (int i = 0; i < 5; i++) begin
			if (!done && ie_m[i] && if_m[i]) begin
				if_m[i] = 1'b0;
				done    = 1'b1;
			end
		end
	endtask

	task automatic pulse_stop();
		@(negedge clk_sys);
		stop = 1'b1;
		@(negedge clk_sys);
		stop = 1'b0;
		if (prep_m && cgb_mode) begin
			spd_m  = ~spd_m;
			prep_m = 1'b0;
		end
		@(negedge clk_sys);
		check_byte("speed_o", {7'b0, spd_m}, {7'b0, speed});
	endtask

	// ------------------------------
	// stimulus
	initial begin
		void'($urandom(SEED));
		reset_ss  = 1'b1;
		axil_req  = '0;
		cgb_mode  = 1'b1;
		cgb_game  = 1'b1;
		fast_boot = 1'b1;
		irq_src   = '0;
		joy_din   = 4'hF;   // no key pressed
		irq_ack   = 1'b0;
		stop      = 1'b0;
		svbk_m    = 1;
		ie_m      = '0;
		if_m      = '0;
		prep_m    = 1'b0;
		spd_m     = 1'b0;
		repeat (3) @(negedge clk_sys);
		reset_ss = 1'b0;
		@(negedge clk_sys);

		test_name = "reset";
		assert (!(axil_rsp.awready || axil_rsp.wready || axil_rsp.arready ||
			axil_rsp.bvalid || axil_rsp.rvalid))
		else fail_run("a ready or valid output was high after reset");
		check_byte("boot_rom_on_o", 8'h01, {7'b0, boot_rom_on});

		test_name = "boot_fast";
		read_check(16'hFF50, 8'h42);

		// random work ram and high ram traffic
		test_name = "ram";
		for (int i = 0; i < RAM_WRITES; i++) begin
			if (i % 4 == 3)
				addr = 16'hFF80 + 16'($urandom_range(126));
			else
				addr = 16'hC000 + 16'($urandom_range(16'h1FFF));
			data = 8'($urandom);
			ram_write(addr, data);
			addrs.push_back(addr);
		end
		foreach (addrs[i])
			read_check(addrs[i], ram_model[ram_key(addrs[i], svbk_m)]);
		test_name = "ram_echo";
		foreach (addrs[i]) begin
			if (addrs[i] < 16'hDE00)   // e000-fdff only
				read_check(addrs[i] + 16'h2000, ram_model[ram_key(addrs[i], svbk_m)]);
		end

		test_name = "svbk";
		read_check(16'hFF70, 8'hF8 | 8'(svbk_m));
		axil_write(16'hFF70, 8'h00);   // 0 stores 1
		svbk_m = 1;
		read_check(16'hFF70, 8'hF9);
		axil_write(16'hFF70, 8'h03);
		svbk_m = 3;
		ram_write(16'hD123, 8'hA5);
		read_check(16'hFF70, 8'hFB);
		axil_write(16'hFF70, 8'h05);
		svbk_m = 5;
		ram_write(16'hD123, 8'h5A);
		read_check(16'hD123, 8'h5A);
		axil_write(16'hFF70, 8'h03);
		svbk_m = 3;
		read_check(16'hD123, 8'hA5);
		read_check(16'hF123, 8'hA5);
		axil_write(16'hFF70, 8'h01);
		svbk_m = 1;

		// dmg mode has no svbk register
		test_name = "svbk_dmg";
		@(negedge clk_sys);
		cgb_mode = 1'b0;
		read_check(16'hFF70, 8'hFF);
		axil_write(16'hFF70, 8'h06);   // ignored
		ram_write(16'hD200, 8'h77);
		@(negedge clk_sys);
		cgb_mode = 1'b1;
		read_check(16'hFF70, 8'hF9);
		read_check(16'hD200, 8'h77);

		test_name = "irq";
		axil_write(16'hFFFF, 8'h1F);
		ie_m = 8'h1F;
		read_check(16'hFFFF, 8'h1F);
		read_check(16'hFF0F, {3'b111, if_m});
		check_irq();
		pulse_src(4'b0001);   // vblank
		read_check(16'hFF0F, {3'b111, if_m});
		check_irq();
		pulse_src(4'b0100);   // timer
		read_check(16'hFF0F, {3'b111, if_m});
		pulse_ack();
		read_check(16'hFF0F, {3'b111, if_m});
		check_irq();
		pulse_src(4'b0010);   // lcd
		pulse_src(4'b1000);   // serial
		read_check(16'hFF0F, {3'b111, if_m});
		check_irq();
		@(negedge clk_sys);
		joy_din = 4'b1011;    // key press gives a falling edge
		repeat (5) @(negedge clk_sys);
		if_m[4] = 1'b1;
		read_check(16'hFF0F, {3'b111, if_m});
		axil_write(16'hFFFF, 8'h10);
		ie_m = 8'h10;
		check_irq();
		axil_write(16'hFF0F, 8'h00);
		if_m = '0;
		check_irq();
		read_check(16'hFF0F, 8'hE0);

		test_name = "p1";
		axil_write(16'hFF00, 8'h10);
		check_byte("joy_sel_o", 8'h01, {6'b0, joy_sel});
		read_check(16'hFF00, {2'b11, 2'b01, joy_din});
		@(negedge clk_sys);
		joy_din = 4'hF;       // release sets no flag
		axil_write(16'hFF00, 8'h20);
		read_check(16'hFF00, 8'hEF);

		test_name = "spare";
		axil_write(16'hFF72, 8'hA5);
		axil_write(16'hFF73, 8'h3C);
		axil_write(16'hFF74, 8'h5A);
		axil_write(16'hFF75, 8'h00);
		read_check(16'hFF72, 8'hA5);
		read_check(16'hFF73, 8'h3C);
		read_check(16'hFF74, 8'h5A);
		read_check(16'hFF75, 8'h00 | 8'h8F);   // only bits 6:4 kept
		axil_write(16'hFF75, 8'h50);
		read_check(16'hFF75, 8'h50 | 8'h8F);

		test_name = "unmapped";
		read_check(16'h0000, 8'hFF);
		read_check(16'h8000, 8'hFF);
		read_check(16'hA000, 8'hFF);
		read_check(16'hFE00, 8'hFF);
		read_check(16'hFF01, 8'hFF);
		read_check(16'hFF40, 8'hFF);

		test_name = "speed";
		read_check(16'hFF4D, {spd_m, 6'h3F, prep_m});
		axil_write(16'hFF4D, 8'h01);
		prep_m = 1'b1;
		read_check(16'hFF4D, {spd_m, 6'h3F, prep_m});
		pulse_stop();
		read_check(16'hFF4D, {spd_m, 6'h3F, prep_m});
		pulse_stop();         // not armed
		read_check(16'hFF4D, {spd_m, 6'h3F, prep_m});
		axil_write(16'hFF4D, 8'h01);
		prep_m = 1'b1;
		@(negedge clk_sys);
		cgb_mode = 1'b0;
		pulse_stop();         // dmg mode keeps the speed
		read_check(16'hFF4D, 8'hFF);
		@(negedge clk_sys);
		cgb_mode = 1'b1;
		read_check(16'hFF4D, {spd_m, 6'h3F, prep_m});
		pulse_stop();
		read_check(16'hFF4D, {spd_m, 6'h3F, prep_m});

		test_name = "overlap";
		write_read_race(16'hC010, 8'h3C, rd);
		ram_model[ram_key(16'hC010, svbk_m)] = 8'h3C;
		check_byte("read after write", 8'h3C, rd);

		// boot rom unmap then svbk decode by game flag
		test_name = "boot_off";
		axil_write(16'hFF50, 8'h01);   // cgb needs 11h
		check_byte("boot_rom_on_o", 8'h01, {7'b0, boot_rom_on});
		axil_write(16'hFF50, 8'h11);
		check_byte("boot_rom_on_o", 8'h00, {7'b0, boot_rom_on});
		read_check(16'hFF50, 8'hFF);
		read_check(16'hFF70, 8'hF8 | 8'(svbk_m));
		@(negedge clk_sys);
		cgb_game = 1'b0;
		read_check(16'hFF70, 8'hFF);
		read_check(16'hFF74, 8'hFF);

		$display("Done: no errors");
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+common
+incdir+verification
common/gb_bus_pkg.sv
logic/axil_cpu_port.sv
logic/addr_decode.sv
interrupts/irq_ctrl.sv
memory/internal_ram.sv
logic/io_regs.sv
logic/gb_sys_bus.sv
verification/tb_gb_sys_bus.sv

// ==== Bender.yml ====
package:
  name: gb_sys_bus

sources:
  - include_dirs:
      - common
    files:
      - common/gb_bus_pkg.sv
      - logic/axil_cpu_port.sv
      - logic/addr_decode.sv
      - interrupts/irq_ctrl.sv
      - memory/internal_ram.sv
      - logic/io_regs.sv
      - logic/gb_sys_bus.sv
  - target: test
    include_dirs:
      - common
      - verification
    files:
      - verification/tb_gb_sys_bus.sv
